//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= titan_lsu_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
SIM_ARGS  ?= +verilator+error+limit+100
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	-./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@grep -qx "Test OK" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- files.f
+incdir+verilog
verilog/titan_lsu_pkg.sv
verilog/titan_ifetch_port.sv
verilog/titan_dmem_port.sv
verilog/titan_lsu_align.sv
verilog/titan_lsu.sv
testbench/titan_lsu_asserts.sv
testbench/titan_lsu_tb.sv

//--- testbench/titan_lsu_asserts.sv
`timescale 1ns/100ps

`include "titan_lsu_consts.svh"

module titan_lsu_asserts
  import titan_lsu_pkg::*;
(
  input logic                   clk_i,
  input logic                   rst_i,
  input logic [`TITAN_XLEN-1:0] pc_i,
  input logic                   ikill_i,
  input logic [`TITAN_XLEN-1:0] idat_i,
  input logic [`TITAN_XLEN-1:0] instr_o,
  input logic [`TITAN_XLEN-1:0] iaddr_o,
  input logic                   icyc_o,
  input logic                   istb_o,
  input logic                   istall_o,
  input core_dreq_t             core_req_i,
  input logic                   dstall_o,
  input logic [`TITAN_XLEN-1:0] data_o,
  input logic [`TITAN_XLEN-1:0] ddat_i,
  input logic                   dack_i,
  input logic                   derr_i,
  input dbus_req_t              dbus_o,
  input logic                   dcyc_o,
  input logic                   dstb_o
);

  int   fail_count;
  logic req_present;

  initial fail_count = 0;

  // Exactly one of read and write
  assign req_present = core_req_i.mread ^ core_req_i.mwrite;

  task automatic note_fail(input string msg);
    fail_count++;
    $error("** Error %0t: %s", $time, msg);
  endtask

  function automatic logic [3:0] want_sel(input core_dreq_t r);
    case (r.size)
      size_byte: want_sel = 4'b0001 << r.addr[1:0];
      size_half: want_sel = r.addr[1] ? 4'b1100 : 4'b0011;
      default:   want_sel = 4'b1111;
    endcase
  endfunction

  function automatic logic [31:0] want_wdata(input core_dreq_t r);
    case (r.size)
      size_byte: want_wdata = {r.wdata[7:0], r.wdata[7:0], r.wdata[7:0], r.wdata[7:0]};
      size_half: want_wdata = {r.wdata[15:0], r.wdata[15:0]};
      default:   want_wdata = r.wdata;
    endcase
  endfunction

  // Expected load result from the raw bus word
  function automatic logic [31:0] want_load(input logic [31:0] word, input logic [1:0] off,
                                            input mem_size_e size, input logic uns);
    logic [31:0] lane;
    case (off)
      2'd0:    lane = word;
      2'd1:    lane = {8'h00, word[31:8]};
      2'd2:    lane = {16'h0000, word[31:16]};
      default: lane = {24'h000000, word[31:24]};
    endcase
    case (size)
      size_byte: want_load = uns ? {24'h0, lane[7:0]} : {{24{lane[7]}}, lane[7:0]};
      size_half: want_load = uns ? {16'h0, lane[15:0]} : {{16{lane[15]}}, lane[15:0]};
      default:   want_load = lane;
    endcase
  endfunction

  a_reset_idle: assert property (@(posedge clk_i)
    $fell(rst_i) |-> !icyc_o && !istb_o && !dcyc_o && !dstb_o && !dbus_o.we)
    else note_fail("bus outputs not idle after reset");

  a_start: assert property (@(posedge clk_i) disable iff (rst_i)
    (!dcyc_o && req_present) |=> dcyc_o && dstb_o)
    else note_fail("request did not start a bus cycle one cycle later");

  a_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    (dcyc_o && !dack_i && !derr_i) |=> dcyc_o && dstb_o && $stable(dbus_o))
    else note_fail("data bus changed while waiting for the slave");

  a_stall: assert property (@(posedge clk_i) disable iff (rst_i)
    dstall_o == (req_present && !dack_i))
    else note_fail("dstall_o does not follow request and ack");

  a_store: assert property (@(posedge clk_i) disable iff (rst_i)
    (dcyc_o && dbus_o.we) |-> dbus_o.addr == core_req_i.addr &&
      dbus_o.sel == want_sel(core_req_i) && dbus_o.wdata == want_wdata(core_req_i))
    else note_fail("store lanes or selects are wrong");

  a_load: assert property (@(posedge clk_i) disable iff (rst_i)
    (dcyc_o && !dbus_o.we && dack_i) |->
      data_o == want_load(ddat_i, core_req_i.addr[1:0], core_req_i.size,
                          core_req_i.is_unsigned))
    else note_fail("load data is wrong");

  // Fetch address and instruction word pass straight through
  a_ipass: assert property (@(posedge clk_i) disable iff (rst_i)
    iaddr_o == pc_i && instr_o == idat_i)
    else note_fail("instruction address or data not passed through");

  a_aligned: assert property (@(posedge clk_i) disable iff (rst_i)
    (pc_i[1:0] != 2'b00) |=> !istb_o && !icyc_o)
    else note_fail("fetch strobe raised for an unaligned pc");

  a_kill: assert property (@(posedge clk_i) disable iff (rst_i)
    ikill_i |=> istall_o)
    else note_fail("no stall in the cycle after a kill");

endmodule

//--- testbench/titan_lsu_tb.sv
`timescale 1ns/100ps

`include "titan_lsu_consts.svh"

module titan_lsu_tb
  import titan_lsu_pkg::*;
();

  localparam int MEM_WORDS  = 64;
  localparam int WAIT_LIMIT = 64;

  logic        clk;
  logic        rst;
  logic [31:0] pc;
  logic [31:0] instr;
  logic        ikill;
  logic [31:0] idat;
  logic        iack;
  logic        ierr;
  logic [31:0] iaddr;
  logic        icyc;
  logic        istb;
  logic        istall;
  core_dreq_t  core_req;
  logic        dstall;
  logic [31:0] data;
  logic [31:0] ddat;
  logic        dack;
  logic        derr;
  dbus_req_t   dbus;
  logic        dcyc;
  logic        dstb;

  logic [31:0] imem [MEM_WORDS];
  logic [31:0] dmem [MEM_WORDS];
  logic [31:0] ilfsr;
  logic [31:0] dlfsr;

  titan_lsu dut (
    .clk_i(clk), .rst_i(rst), .pc_i(pc), .instr_o(instr), .ikill_i(ikill),
    .idat_i(idat), .iack_i(iack), .ierr_i(ierr), .iaddr_o(iaddr), .icyc_o(icyc),
    .istb_o(istb), .istall_o(istall), .core_req_i(core_req), .dstall_o(dstall),
    .data_o(data), .ddat_i(ddat), .dack_i(dack), .derr_i(derr), .dbus_o(dbus),
    .dcyc_o(dcyc), .dstb_o(dstb)
  );

  bind titan_lsu titan_lsu_asserts u_asserts (
    .clk_i(clk_i), .rst_i(rst_i), .pc_i(pc_i), .ikill_i(ikill_i), .idat_i(idat_i),
    .instr_o(instr_o), .iaddr_o(iaddr_o), .icyc_o(icyc_o),
    .istb_o(istb_o), .istall_o(istall_o), .core_req_i(core_req_i), .dstall_o(dstall_o),
    .data_o(data_o), .ddat_i(ddat_i), .dack_i(dack_i), .derr_i(derr_i),
    .dbus_o(dbus_o), .dcyc_o(dcyc_o), .dstb_o(dstb_o)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  function automatic logic [31:0] galois_step(input logic [31:0] s);
    galois_step = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  task automatic draw_bits(inout logic [31:0] state, input int n, output logic [31:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      state = galois_step(state);
      v = {v[30:0], state[0]};
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1, "simulation stopped");
  endtask

  // Instruction slave takes the address at the falling edge where it is stable
  initial begin : ibus_slave
    logic [31:0] delay;
    logic [31:0] roll;
    logic [31:0] addr_seen;
    logic        busy;
    busy = 1'b0;
    delay = '0;
    forever begin
      @(negedge clk);
      addr_seen = iaddr;
      @(posedge clk);
      #1;
      iack = 1'b0;
      ierr = 1'b0;
      if (icyc && istb) begin
        if (!busy) begin
          busy = 1'b1;
          draw_bits(ilfsr, 2, delay);
        end
        if (delay == 0) begin
          draw_bits(ilfsr, 4, roll);
          busy = 1'b0;
          ierr = (roll == 0);
          iack = (roll != 0);
          idat = imem[addr_seen[7:2]];
        end else begin
          delay = delay - 1;
        end
      end
    end
  end

  initial begin : dbus_slave
    logic [31:0] delay;
    logic [31:0] roll;
    logic [5:0]  idx;
    logic        busy;
    busy = 1'b0;
    delay = '0;
    forever begin
      @(posedge clk);
      #1;
      dack = 1'b0;
      derr = 1'b0;
      if (dcyc && dstb) begin
        if (!busy) begin
          busy = 1'b1;
          draw_bits(dlfsr, 2, delay);
        end
        if (delay == 0) begin
          draw_bits(dlfsr, 4, roll);
          busy = 1'b0;
          idx = dbus.addr[7:2];
          if (roll == 0) begin
            derr = 1'b1;
          end else begin
            for (int b = 0; b < 4; b++) begin
              if (dbus.we && dbus.sel[b]) begin
                dmem[idx][8*b +: 8] = dbus.wdata[8*b +: 8];
              end
            end
            ddat = dmem[idx];
            dack = 1'b1;
          end
        end else begin
          delay = delay - 1;
        end
      end
    end
  end

  always @(negedge clk) begin
    if (dut.u_asserts.fail_count != 0) begin
      abort_run("An assertion on the DUT failed");
    end
  end

  task automatic fetch_at(input logic [31:0] addr);
    int n;
    n = 0;
    @(posedge clk);
    #1;
    pc = addr;
    @(negedge clk);
    while (istall && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (istall) begin
      abort_run("Instruction fetch never completed");
    end
  endtask

  task automatic unaligned_pc(input logic [31:0] addr);
    @(posedge clk);
    #1;
    pc = addr;
    repeat (3) @(posedge clk);
  endtask

  task automatic kill_pulse();
    @(posedge clk);
    #1;
    ikill = 1'b1;
    @(posedge clk);
    #1;
    ikill = 1'b0;
  endtask

  // Holds the request until ack, or withdraws it after an error
  task automatic mem_access(input logic [31:0] addr, input logic [31:0] wdata,
                            input mem_size_e size, input logic uns, input logic write);
    int n;
    n = 0;
    @(posedge clk);
    #1;
    core_req.addr = addr;
    core_req.wdata = wdata;
    core_req.size = size;
    core_req.is_unsigned = uns;
    core_req.mread = !write;
    core_req.mwrite = write;
    @(negedge clk);
    while (dstall && !derr && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (dstall && !derr) begin
      abort_run("Data bus request never completed");
    end
    @(posedge clk);
    #1;
    core_req.mread = 1'b0;
    core_req.mwrite = 1'b0;
  endtask

  task automatic fetch_sequence();
    for (int i = 0; i < 12; i++) begin
      fetch_at(32'(i * 4));
      if (i % 3 == 1) begin
        unaligned_pc(32'(i * 4 + 2));
      end
      if (i % 4 == 2) begin
        kill_pulse();
      end
    end
  endtask

  task automatic data_sequence();
    logic [31:0] base;
    mem_access(32'h0000_0010, 32'hdead_beef, size_word, 1'b0, 1'b1);
    for (int off = 0; off < 4; off++) begin
      mem_access(32'h0000_0020 + 32'(off), 32'h0000_0081 + 32'(off * 17), size_byte, 1'b0, 1'b1);
    end
    mem_access(32'h0000_0030, 32'h1234_8b7c, size_half, 1'b0, 1'b1);
    mem_access(32'h0000_0032, 32'h5678_41e2, size_half, 1'b0, 1'b1);
    // Loads over stored and filled words
    for (int w = 0; w < 6; w++) begin
      base = 32'(w * 16 + 16);
      for (int off = 0; off < 4; off++) begin
        mem_access(base + 32'(off), '0, size_byte, 1'b0, 1'b0);
        mem_access(base + 32'(off), '0, size_byte, 1'b1, 1'b0);
      end
      for (int off = 0; off < 4; off += 2) begin
        mem_access(base + 32'(off), '0, size_half, 1'b0, 1'b0);
        mem_access(base + 32'(off), '0, size_half, 1'b1, 1'b0);
      end
      mem_access(base, '0, size_word, 1'b0, 1'b0);
    end
  endtask

  initial begin
    rst = 1'b1;
    pc = '0;
    ikill = 1'b0;
    idat = '0;
    iack = 1'b0;
    ierr = 1'b0;
    core_req = '0;
    ddat = '0;
    dack = 1'b0;
    derr = 1'b0;
    ilfsr = 32'd79;
    dlfsr = 32'd79;
    for (int i = 0; i < MEM_WORDS; i++) begin
      imem[i] = {8'(i), 8'(i * 5 + 1), 8'(~i), 8'h13};
      dmem[i] = {8'(i * 7 + 8'h81), 8'(i * 3), 8'(8'hf0 - i), 8'(i + 8'h7c)};
    end
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    fork
      fetch_sequence();
      data_sequence();
    join
    repeat (4) @(negedge clk);
    if (dut.u_asserts.fail_count == 0) begin
      $display("Test OK");
      $finish;
    end else begin
      abort_run("An assertion on the DUT failed");
    end
  end

endmodule

//--- verilog/titan_dmem_port.sv
`timescale 1ns/100ps

`include "titan_lsu_consts.svh"

module titan_dmem_port
  import titan_lsu_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  core_dreq_t             core_req_i,
  input  dbus_req_t              store_bus_i,
  input  logic                   dack_i,
  input  logic                   derr_i,
  output logic                   dstall_o,
  output dbus_req_t              dbus_o,
  output logic                   dcyc_o,
  output logic                   dstb_o,
  output mem_size_e              lsize_o,
  output logic                   lunsigned_o,
  output logic [`TITAN_OFFW-1:0] loff_o
);

  typedef enum logic {
    st_idle,
    st_bus
  } dstate_e;

  dstate_e                state_q;
  logic                   req_valid;
  logic                   start;
  logic                   done;
  logic                   we_q;
  logic [`TITAN_XLEN-1:0] addr_q;
  logic [`TITAN_XLEN-1:0] wdata_q;
  logic [`TITAN_SELW-1:0] sel_q;

  // Exactly one of read and write makes a request
  assign req_valid = core_req_i.mread ^ core_req_i.mwrite;

  assign start = (state_q == st_idle) & req_valid;
  assign done  = (state_q == st_bus) & (dack_i | derr_i);

  // Stall falls in the ack cycle; an error keeps it high
  assign dstall_o = req_valid & ~dack_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= st_idle;
      dcyc_o  <= 1'b0;
      dstb_o  <= 1'b0;
      we_q    <= 1'b0;
    end else begin
      case (state_q)
        st_idle: begin
          if (start) begin
            state_q <= st_bus;
            dcyc_o  <= 1'b1;
            dstb_o  <= 1'b1;
            we_q    <= store_bus_i.we;
          end
        end
        st_bus: begin
          // Hold everything until the slave answers
          if (done) begin
            state_q <= st_idle;
            dcyc_o  <= 1'b0;
            dstb_o  <= 1'b0;
            we_q    <= 1'b0;
          end
        end
        default: begin
          state_q <= st_idle;
          dcyc_o  <= 1'b0;
          dstb_o  <= 1'b0;
          we_q    <= 1'b0;
        end
      endcase
    end
  end

  // Request payload and load format, captured as the cycle starts
  always_ff @(posedge clk_i) begin
    if (start) begin
      addr_q      <= store_bus_i.addr;
      wdata_q     <= store_bus_i.wdata;
      sel_q       <= store_bus_i.sel;
      lsize_o     <= core_req_i.size;
      lunsigned_o <= core_req_i.is_unsigned;
      loff_o      <= core_req_i.addr[`TITAN_OFFW-1:0];
    end
  end

  assign dbus_o = '{
    addr:  addr_q,
    wdata: wdata_q,
    sel:   sel_q,
    we:    we_q
  };

endmodule

//--- verilog/titan_ifetch_port.sv
`timescale 1ns/100ps

`include "titan_lsu_consts.svh"

module titan_ifetch_port (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic [`TITAN_XLEN-1:0] pc_i,
  input  logic                   ikill_i,
  input  logic [`TITAN_XLEN-1:0] idat_i,
  input  logic                   iack_i,
  input  logic                   ierr_i,
  output logic [`TITAN_XLEN-1:0] instr_o,
  output logic [`TITAN_XLEN-1:0] iaddr_o,
  output logic                   icyc_o,
  output logic                   istb_o,
  output logic                   istall_o
);

  typedef enum logic {
    st_fetch,
    st_kill
  } istate_e;

  istate_e state_q;
  logic    pc_aligned;
  logic    kill;

  assign pc_aligned = (pc_i[`TITAN_OFFW-1:0] == '0);

  // One-cycle bubble after a kill, also the first cycle out of reset
  assign kill = (state_q == st_kill);

  // Address and instruction pass straight through
  assign iaddr_o = pc_i;
  assign instr_o = idat_i;

  // Core waits for an ack, and always through the bubble
  assign istall_o = ~iack_i | kill;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= st_kill;
      icyc_o  <= 1'b0;
      istb_o  <= 1'b0;
    end else begin
      // Only word aligned fetches go out on the bus
      icyc_o <= pc_aligned;
      // Strobe rests for a cycle once the slave has answered
      istb_o <= pc_aligned & ~(iack_i | ierr_i);

      case (state_q)
        st_fetch: begin
          if (ikill_i) begin
            state_q <= st_kill;
          end
        end
        st_kill: begin
          state_q <= st_fetch;
        end
        default: begin
          state_q <= st_fetch;
        end
      endcase
    end
  end

endmodule

//--- verilog/titan_lsu.sv
`timescale 1ns/100ps

`include "titan_lsu_consts.svh"

module titan_lsu
  import titan_lsu_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_i,
  // Instruction side
  input  logic [`TITAN_XLEN-1:0] pc_i,
  output logic [`TITAN_XLEN-1:0] instr_o,
  input  logic                   ikill_i,
  input  logic [`TITAN_XLEN-1:0] idat_i,
  input  logic                   iack_i,
  input  logic                   ierr_i,
  output logic [`TITAN_XLEN-1:0] iaddr_o,
  output logic                   icyc_o,
  output logic                   istb_o,
  output logic                   istall_o,
  // Data side
  input  core_dreq_t             core_req_i,
  output logic                   dstall_o,
  output logic [`TITAN_XLEN-1:0] data_o,
  input  logic [`TITAN_XLEN-1:0] ddat_i,
  input  logic                   dack_i,
  input  logic                   derr_i,
  output dbus_req_t              dbus_o,
  output logic                   dcyc_o,
  output logic                   dstb_o
);

  dbus_req_t              store_bus;
  mem_size_e              lsize;
  logic                   lunsigned;
  logic [`TITAN_OFFW-1:0] loff;

  titan_ifetch_port u_ifetch (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .pc_i     (pc_i),
    .ikill_i  (ikill_i),
    .idat_i   (idat_i),
    .iack_i   (iack_i),
    .ierr_i   (ierr_i),
    .instr_o  (instr_o),
    .iaddr_o  (iaddr_o),
    .icyc_o   (icyc_o),
    .istb_o   (istb_o),
    .istall_o (istall_o)
  );

  titan_dmem_port u_dmem (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .core_req_i  (core_req_i),
    .store_bus_i (store_bus),
    .dack_i      (dack_i),
    .derr_i      (derr_i),
    .dstall_o    (dstall_o),
    .dbus_o      (dbus_o),
    .dcyc_o      (dcyc_o),
    .dstb_o      (dstb_o),
    .lsize_o     (lsize),
    .lunsigned_o (lunsigned),
    .loff_o      (loff)
  );

  // Store placement from the live request, load extraction from the latched format
  titan_lsu_align u_align (
    .core_req_i  (core_req_i),
    .lsize_i     (lsize),
    .lunsigned_i (lunsigned),
    .loff_i      (loff),
    .ddat_i      (ddat_i),
    .store_bus_o (store_bus),
    .data_o      (data_o)
  );

endmodule

//--- verilog/titan_lsu_align.sv
`timescale 1ns/100ps

`include "titan_lsu_consts.svh"

module titan_lsu_align
  import titan_lsu_pkg::*;
(
  input  core_dreq_t             core_req_i,
  input  mem_size_e              lsize_i,
  input  logic                   lunsigned_i,
  input  logic [`TITAN_OFFW-1:0] loff_i,
  input  logic [`TITAN_XLEN-1:0] ddat_i,
  output dbus_req_t              store_bus_o,
  output logic [`TITAN_XLEN-1:0] data_o
);

  logic [`TITAN_OFFW-1:0] soff;
  logic [`TITAN_XLEN-1:0] lword;

  assign soff = core_req_i.addr[`TITAN_OFFW-1:0];

  // Store side
  always_comb begin
    store_bus_o.addr = core_req_i.addr;
    store_bus_o.we   = core_req_i.mwrite;
    case (core_req_i.size)
      size_byte: begin
        // Byte on every lane, select picks one
        store_bus_o.wdata = {4{core_req_i.wdata[7:0]}};
        store_bus_o.sel   = {{(`TITAN_SELW-1){1'b0}}, 1'b1} << soff;
      end
      size_half: begin
        store_bus_o.wdata = {2{core_req_i.wdata[15:0]}};
        store_bus_o.sel   = soff[1] ? 4'hc : 4'h3;
      end
      default: begin
        store_bus_o.wdata = core_req_i.wdata;
        store_bus_o.sel   = 4'hf;
      end
    endcase
  end

  // Load side, bring the addressed lane down to bit 0
  assign lword = ddat_i >> {loff_i, 3'b000};

  always_comb begin
    case (lsize_i)
      size_byte: begin
        data_o = {{24{~lunsigned_i & lword[7]}}, lword[7:0]};
      end
      size_half: begin
        data_o = {{16{~lunsigned_i & lword[15]}}, lword[15:0]};
      end
      default: begin
        data_o = lword;
      end
    endcase
  end

endmodule

//--- verilog/titan_lsu_consts.svh
`ifndef TITAN_LSU_CONSTS_SVH
`define TITAN_LSU_CONSTS_SVH

// Data and address width, one machine word
`define TITAN_XLEN 32

// One byte select per lane
`define TITAN_SELW 4

// Byte offset inside a word
`define TITAN_OFFW 2

`endif

//--- verilog/titan_lsu_pkg.sv
`include "titan_lsu_consts.svh"

package titan_lsu_pkg;

  // Access size as issued by the core
  typedef enum logic [1:0] {
    size_byte = 2'd0,
    size_half = 2'd1,
    size_word = 2'd2
  } mem_size_e;

  // Data bus request, registered by the data port for one bus cycle
  typedef struct packed {
    logic [`TITAN_XLEN-1:0] addr;
    logic [`TITAN_XLEN-1:0] wdata;
    logic [`TITAN_SELW-1:0] sel;
    logic                   we;
  } dbus_req_t;

  // Load or store request from the core
  // mread and mwrite stay steady until the stall drops
  typedef struct packed {
    logic [`TITAN_XLEN-1:0] addr;
    logic [`TITAN_XLEN-1:0] wdata;
    mem_size_e              size;
    logic                   is_unsigned;
    logic                   mread;
    logic                   mwrite;
  } core_dreq_t;

endpackage
